// File: compile.f
+incdir+hw
hw/sniffer_pkg.sv
hw/ctrl_regs.sv
hw/mem_window.sv
hw/dram_arbiter.sv
hw/dram_sniffer_top.sv
dv/dram_model.sv
dv/sniffer_chk.sv
dv/sniffer_tb.sv

// File: dv/dram_model.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module dram_model (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stall,
  input  sniffer_pkg::mem_req_t ddr_req,
  output logic                  ddr_rdy,
  output sniffer_pkg::mem_rsp_t ddr_rsp
);

  localparam int LAT = 3;

  logic [`SNIFF_DATA_W-1:0] mem [logic [`SNIFF_ADDR_W-1:0]];
  sniffer_pkg::mem_rsp_t    pipe [LAT];

  // untouched beats read back a pattern built from the whole address
  function automatic logic [63:0] fill_word(logic [31:0] a);
    return {~a, a};
  endfunction

  assign ddr_rdy = !stall;
  assign ddr_rsp = pipe[LAT-1];

  always @(posedge clk) begin : model
    logic [63:0] w;
    if (rst) begin
      for (int i = 0; i < LAT; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      for (int i = LAT - 1; i > 0; i--) begin
        pipe[i] <= pipe[i-1];
      end
      pipe[0] <= '0;
      if (ddr_req.valid && ddr_rdy) begin
        w = mem.exists(ddr_req.addr) ? mem[ddr_req.addr] : fill_word(ddr_req.addr);
        if (ddr_req.cmd == sniffer_pkg::CMD_READ) begin
          pipe[0] <= {1'b1, w};
        end else begin
          // mask bit set keeps the old byte
          for (int b = 0; b < `SNIFF_MASK_W; b++) begin
            if (!ddr_req.mask[b]) begin
              w[b*8 +: 8] = ddr_req.wdata[b*8 +: 8];
            end
          end
          mem[ddr_req.addr] = w;
        end
      end
    end
  end

endmodule

// File: dv/sniffer_chk.sv
`timescale 1ns/1ps

module sniffer_chk (
  input logic                  clk,
  input logic                  rst,
  input sniffer_pkg::mem_req_t ddr_req,
  input logic                  ddr_rdy,
  input logic                  app_rdy,
  input logic                  override_en,
  input sniffer_pkg::port_id_e override_sel,
  input logic                  ctrl_pready,
  input logic                  mem_pready
);

  // stalled command must not change
  assert property (@(posedge clk) disable iff (rst)
    ddr_req.valid && !ddr_rdy |=> $stable(ddr_req))
    else $error("ddr_req changed while stalled");

  assert property (@(posedge clk) disable iff (rst)
    !(app_rdy && override_en && override_sel == sniffer_pkg::PORT_SNIFF))
    else $error("app port granted during window override");

  assert property (@(posedge clk) disable iff (rst) ctrl_pready |=> !ctrl_pready)
    else $error("ctrl pready held longer than one cycle");

  assert property (@(posedge clk) disable iff (rst) mem_pready |=> !mem_pready)
    else $error("window pready held longer than one cycle");

endmodule

bind dram_sniffer_top sniffer_chk u_chk (
  .clk          (clk),
  .rst          (rst),
  .ddr_req      (ddr_req),
  .ddr_rdy      (ddr_rdy),
  .app_rdy      (app_rdy),
  .override_en  (override_en),
  .override_sel (override_sel),
  .ctrl_pready  (ctrl_apb_out.pready),
  .mem_pready   (mem_apb_out.pready)
);

// File: dv/sniffer_tb.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module sniffer_tb;

  localparam int WAIT_MAX = 400;

  typedef enum {T_CTRL, T_WIN, T_APP} target_e;
  typedef enum {OP_WR, OP_RD, OP_RD_ERR, OP_MIX, OP_POST, OP_COLLECT} op_e;

  typedef struct {
    int          test;
    target_e     tgt;
    op_e         op;
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  strb;
    logic [63:0] exp;
  } entry_t;

  logic                  clk;
  logic                  rst;
  logic                  phy_ready;
  logic                  stall;
  sniffer_pkg::apb_req_t ctrl_apb_in;
  sniffer_pkg::apb_rsp_t ctrl_apb_out;
  sniffer_pkg::apb_req_t mem_apb_in;
  sniffer_pkg::apb_rsp_t mem_apb_out;
  sniffer_pkg::mem_req_t app_req;
  logic                  app_rdy;
  sniffer_pkg::mem_rsp_t app_rsp;
  sniffer_pkg::mem_req_t ddr_req;
  logic                  ddr_rdy;
  sniffer_pkg::mem_rsp_t ddr_rsp;

  entry_t      table_q[$];
  logic [63:0] app_q[$];
  logic [63:0] ref_mem [logic [31:0]];
  logic [15:0] cur_base;
  logic [15:0] lfsr_q = 16'd67;
  logic [63:0] post_exp;
  int          checks;
  int          errors;
  int          test_errs;
  string       test_names[7];

  dram_sniffer_top dut (
    .clk          (clk),
    .rst          (rst),
    .ctrl_apb_in  (ctrl_apb_in),
    .ctrl_apb_out (ctrl_apb_out),
    .mem_apb_in   (mem_apb_in),
    .mem_apb_out  (mem_apb_out),
    .phy_ready    (phy_ready),
    .app_req      (app_req),
    .app_rdy      (app_rdy),
    .app_rsp      (app_rsp),
    .ddr_req      (ddr_req),
    .ddr_rdy      (ddr_rdy),
    .ddr_rsp      (ddr_rsp)
  );

  dram_model u_dram_model (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .ddr_req (ddr_req),
    .ddr_rdy (ddr_rdy),
    .ddr_rsp (ddr_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_step();
    end
    return w;
  endfunction

  // roughly one cycle in four stalls
  always @(negedge clk) begin
    if (rst) begin
      stall = 1'b0;
    end else begin
      stall = lfsr_step() & lfsr_step();
    end
  end

  always @(negedge clk) begin
    if (!rst && app_rsp.valid) begin
      app_q.push_back(app_rsp.rdata);
    end
  end

  function automatic logic [63:0] fill_word(logic [31:0] a);
    return {~a, a};
  endfunction

  function automatic logic [63:0] ref_read(logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic void ref_write(logic [31:0] a, logic [63:0] d, logic [7:0] be);
    logic [63:0] w;
    w = ref_read(a);
    for (int i = 0; i < 8; i++) begin
      if (be[i]) begin
        w[i*8 +: 8] = d[i*8 +: 8];
      end
    end
    ref_mem[a] = w;
  endfunction

  function automatic logic [31:0] win_beat(logic [11:0] paddr);
    return {7'b0, cur_base, paddr[11:3]};
  endfunction

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timed out waiting for %s at %0t ns", what, $time);
    errors++;
    test_errs++;
  endtask

  task automatic drive_apb(input bit is_ctrl, input sniffer_pkg::apb_req_t r);
    if (is_ctrl) begin
      ctrl_apb_in = r;
    end else begin
      mem_apb_in = r;
    end
  endtask

  task automatic apb_xfer(input bit is_ctrl, input bit wr, input logic [11:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic slverr);
    sniffer_pkg::apb_req_t r;
    sniffer_pkg::apb_rsp_t s;
    int n;
    @(negedge clk);
    r = '0;
    r.psel = 1'b1;
    r.pwrite = wr;
    r.paddr = addr;
    r.pwdata = wdata;
    r.pstrb = strb;
    drive_apb(is_ctrl, r);
    @(negedge clk);
    r.penable = 1'b1;
    drive_apb(is_ctrl, r);
    #1;
    s = is_ctrl ? ctrl_apb_out : mem_apb_out;
    n = 0;
    while (!s.pready && n < WAIT_MAX) begin
      @(negedge clk);
      #1;
      s = is_ctrl ? ctrl_apb_out : mem_apb_out;
      n++;
    end
    if (!s.pready) begin
      note_timeout("apb pready");
    end
    rdata = s.prdata;
    slverr = s.pslverr;
    @(negedge clk);
    drive_apb(is_ctrl, '0);
  endtask

  task automatic app_issue(input sniffer_pkg::mem_cmd_e cmd, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic [7:0] mask);
    int n;
    @(negedge clk);
    app_req.valid = 1'b1;
    app_req.cmd = cmd;
    app_req.addr = addr;
    app_req.wdata = wdata;
    app_req.mask = mask;
    #1;
    n = 0;
    while (!app_rdy && n < WAIT_MAX) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!app_rdy) begin
      note_timeout("app port grant");
    end
    @(negedge clk);
    app_req.valid = 1'b0;
  endtask

  task automatic app_collect(input string what, input logic [63:0] exp);
    int n;
    n = 0;
    while (app_q.size() == 0 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (app_q.size() == 0) begin
      note_timeout("app read data");
    end else begin
      check(what, app_q.pop_front(), exp);
    end
  endtask

  // app reads and window reads in flight together
  task automatic run_mix(input logic [31:0] beat);
    logic [63:0] exp_q[$];
    logic [63:0] w;
    logic [31:0] rd;
    logic        err;
    fork
      begin
        for (int k = 0; k < 6; k++) begin
          exp_q.push_back(ref_read(beat + k));
          app_issue(sniffer_pkg::CMD_READ, beat + k, '0, '1);
        end
      end
      begin
        for (int k = 0; k < 4; k++) begin
          w = ref_read(win_beat(12'(k * 4)));
          apb_xfer(1'b0, 1'b0, 12'(k * 4), '0, '0, rd, err);
          check("mixed window read", rd, (k % 2) ? w[63:32] : w[31:0]);
        end
      end
    join
    while (exp_q.size() > 0) begin
      app_collect("mixed app read", exp_q.pop_front());
    end
  endtask

  // random write data is drawn here, before the clock runs
  task automatic add(input int test, input target_e tgt, input op_e op,
                     input logic [31:0] addr, input logic [63:0] data, input logic [7:0] strb,
                     input logic [63:0] exp, input bit rnd);
    entry_t      e;
    logic [63:0] d;
    d = rnd ? {32'h0, rand_word()} : data;
    e = '{test, tgt, op, addr, d, strb, exp};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    test_names = '{"", "reset values", "register access", "window byte merge",
                   "window to app mapping", "interleaved reads", "override conflict"};
    add(1, T_CTRL, OP_RD,     `SNIFF_REG_CTRL,   0, 4'hf, 0, 0);
    add(1, T_CTRL, OP_RD,     `SNIFF_REG_BASE,   0, 4'hf, 0, 0);
    add(1, T_CTRL, OP_RD,     `SNIFF_REG_STATUS, 0, 4'hf, 1, 0);
    add(1, T_CTRL, OP_RD_ERR, 12'h00c,           0, 4'hf, 0, 0);
    add(2, T_CTRL, OP_WR,     `SNIFF_REG_BASE,   64'h00a5, 4'hf, 0, 0);
    add(2, T_CTRL, OP_RD,     `SNIFF_REG_BASE,   0, 4'hf, 64'h00a5, 0);
    add(2, T_CTRL, OP_WR,     `SNIFF_REG_CTRL,   64'h2, 4'hf, 0, 0);
    add(2, T_CTRL, OP_RD,     `SNIFF_REG_CTRL,   0, 4'hf, 64'h2, 0);
    add(2, T_CTRL, OP_WR,     `SNIFF_REG_CTRL,   64'h1, 4'hf, 0, 0);
    add(2, T_CTRL, OP_RD,     `SNIFF_REG_CTRL,   0, 4'hf, 64'h1, 0);
    add(2, T_CTRL, OP_WR,     `SNIFF_REG_CTRL,   64'h0, 4'hf, 0, 0);
    add(2, T_CTRL, OP_WR,     `SNIFF_REG_STATUS, 64'hff, 4'hf, 0, 0);
    add(2, T_CTRL, OP_RD,     `SNIFF_REG_STATUS, 0, 4'hf, 1, 0);
    add(3, T_WIN,  OP_WR,     12'h000, 0, 4'hf, 0, 1);
    add(3, T_WIN,  OP_WR,     12'h004, 0, 4'h3, 0, 1);
    add(3, T_WIN,  OP_WR,     12'h004, 0, 4'h8, 0, 1);
    add(3, T_WIN,  OP_WR,     12'h008, 64'h11223344, 4'h5, 0, 0);
    add(3, T_WIN,  OP_WR,     12'h00c, 0, 4'h6, 0, 1);
    add(3, T_WIN,  OP_RD,     12'h000, 0, 4'hf, 0, 0);
    add(3, T_WIN,  OP_RD,     12'h004, 0, 4'hf, 0, 0);
    add(3, T_WIN,  OP_RD,     12'h008, 0, 4'hf, 0, 0);
    add(3, T_WIN,  OP_RD,     12'h00c, 0, 4'hf, 0, 0);
    add(4, T_CTRL, OP_WR,     `SNIFF_REG_BASE, 64'h0012, 4'hf, 0, 0);
    add(4, T_WIN,  OP_WR,     12'h010, 64'hcafef00d, 4'hf, 0, 0);
    add(4, T_APP,  OP_RD,     32'h0000_2402, 0, 8'hff, 0, 0);
    add(4, T_CTRL, OP_WR,     `SNIFF_REG_BASE, 64'h0034, 4'hf, 0, 0);
    add(4, T_WIN,  OP_RD,     12'h010, 0, 4'hf, 0, 0);
    add(4, T_APP,  OP_WR,     32'h0000_6803, 64'h0123_4567_89ab_cdef, 8'h0f, 0, 0);
    add(4, T_WIN,  OP_RD,     12'h018, 0, 4'hf, 0, 0);
    add(5, T_APP,  OP_MIX,    32'h0000_6800, 0, 8'hff, 0, 0);
    add(6, T_CTRL, OP_WR,     `SNIFF_REG_CTRL, 64'h3, 4'hf, 0, 0);
    add(6, T_APP,  OP_POST,   32'h0000_6803, 0, 8'hff, 0, 0);
    add(6, T_CTRL, OP_RD,     `SNIFF_REG_STATUS, 0, 4'hf, 64'h7, 0);
    add(6, T_CTRL, OP_WR,     `SNIFF_REG_CTRL, 64'h4, 4'hf, 0, 0);
    add(6, T_CTRL, OP_RD,     `SNIFF_REG_STATUS, 0, 4'hf, 64'h1, 0);
    add(6, T_APP,  OP_COLLECT, 32'h0000_6803, 0, 8'hff, 0, 0);
  endtask

  task automatic run_entry(input entry_t e);
    logic [31:0] rd;
    logic        err;
    logic [63:0] w;
    case (e.tgt)
      T_CTRL: begin
        apb_xfer(1'b1, e.op == OP_WR, e.addr[11:0], e.data[31:0], e.strb[3:0], rd, err);
        if (e.op == OP_WR) begin
          if (e.addr[11:0] == `SNIFF_REG_BASE) begin
            if (e.strb[0]) begin
              cur_base[7:0] = e.data[7:0];
            end
            if (e.strb[1]) begin
              cur_base[15:8] = e.data[15:8];
            end
          end
        end else if (e.op == OP_RD_ERR) begin
          check("unmapped pslverr", err, 1);
        end else begin
          check("ctrl read", rd, e.exp);
          check("ctrl pslverr", err, 0);
        end
      end
      T_WIN: begin
        if (e.op == OP_WR) begin
          apb_xfer(1'b0, 1'b1, e.addr[11:0], e.data[31:0], e.strb[3:0], rd, err);
          check("window write pslverr", err, 0);
          ref_write(win_beat(e.addr[11:0]), {2{e.data[31:0]}},
                    e.addr[2] ? {e.strb[3:0], 4'h0} : {4'h0, e.strb[3:0]});
        end else begin
          w = ref_read(win_beat(e.addr[11:0]));
          apb_xfer(1'b0, 1'b0, e.addr[11:0], '0, '0, rd, err);
          check("window read", rd, e.addr[2] ? w[63:32] : w[31:0]);
          check("window read pslverr", err, 0);
        end
      end
      default: begin
        case (e.op)
          OP_WR: begin
            app_issue(sniffer_pkg::CMD_WRITE, e.addr, e.data, ~e.strb);
            ref_write(e.addr, e.data, e.strb);
          end
          OP_RD: begin
            w = ref_read(e.addr);
            app_issue(sniffer_pkg::CMD_READ, e.addr, '0, '1);
            app_collect("app read", w);
          end
          OP_POST: begin
            post_exp = ref_read(e.addr);
            fork
              app_issue(sniffer_pkg::CMD_READ, e.addr, '0, '1);
            join_none
          end
          OP_COLLECT: app_collect("held app read", post_exp);
          default: run_mix(e.addr);
        endcase
      end
    endcase
  endtask

  initial begin
    repeat (100000) @(posedge clk);
    $display("simulation did not finish within the cycle limit");
    $display("Test failed");
    $finish;
  end

  initial begin
    int cur_test;
    rst = 1'b1;
    phy_ready = 1'b1;
    stall = 1'b0;
    ctrl_apb_in = '0;
    mem_apb_in = '0;
    app_req = '0;
    cur_base = '0;
    checks = 0;
    errors = 0;
    test_errs = 0;
    build_table();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    cur_test = table_q[0].test;
    foreach (table_q[i]) begin
      if (table_q[i].test != cur_test) begin
        $display("test %0d %s: %0d errors", cur_test, test_names[cur_test], test_errs);
        test_errs = 0;
        cur_test = table_q[i].test;
      end
      run_entry(table_q[i]);
    end
    $display("test %0d %s: %0d errors", cur_test, test_names[cur_test], test_errs);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: hw/ctrl_regs.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module ctrl_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  sniffer_pkg::apb_req_t    apb_in,
  output sniffer_pkg::apb_rsp_t    apb_out,
  output logic [`SNIFF_BASE_W-1:0] window_base,
  output logic                     override_en,
  output sniffer_pkg::port_id_e    override_sel,
  input  sniffer_pkg::arb_state_e  arb_state,
  input  logic                     conflict,
  output logic                     conflict_clr,
  input  sniffer_pkg::win_state_e  win_state,
  input  logic                     phy_ready
);

  logic        access;
  logic        wr_en;
  logic [11:0] offset;
  logic        hit_ctrl;
  logic        hit_base;
  logic        hit_status;
  logic        ctrl_wr;

  assign access = apb_in.psel && apb_in.penable;
  assign wr_en  = access && apb_in.pwrite;

  // word aligned decode
  assign offset     = {apb_in.paddr[11:2], 2'b00};
  assign hit_ctrl   = (offset == `SNIFF_REG_CTRL);
  assign hit_base   = (offset == `SNIFF_REG_BASE);
  assign hit_status = (offset == `SNIFF_REG_STATUS);

  // ctrl fields all live in byte 0
  assign ctrl_wr = wr_en && hit_ctrl && apb_in.pstrb[0];

  // no wait states, every access phase completes at once
  always_comb begin
    apb_out.pready  = access;
    apb_out.pslverr = access && !(hit_ctrl || hit_base || hit_status);
    apb_out.prdata  = '0;
    if (hit_ctrl) begin
      apb_out.prdata[0] = override_en;
      apb_out.prdata[1] = override_sel;
    end else if (hit_base) begin
      apb_out.prdata[`SNIFF_BASE_W-1:0] = window_base;
    end else if (hit_status) begin
      apb_out.prdata[0]   = phy_ready;
      apb_out.prdata[1]   = arb_state;
      apb_out.prdata[2]   = conflict;
      apb_out.prdata[4:3] = win_state;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      override_en  <= 1'b0;
      override_sel <= sniffer_pkg::PORT_APP;
      window_base  <= '0;
      conflict_clr <= 1'b0;
    end else begin
      // bit 2 of ctrl is a self clearing strobe
      conflict_clr <= ctrl_wr && apb_in.pwdata[2];
      if (ctrl_wr) begin
        override_en  <= apb_in.pwdata[0];
        override_sel <= sniffer_pkg::port_id_e'(apb_in.pwdata[1]);
      end
      if (wr_en && hit_base) begin
        for (int b = 0; b < `SNIFF_BASE_W / 8; b++) begin
          if (apb_in.pstrb[b]) begin
            window_base[b*8 +: 8] <= apb_in.pwdata[b*8 +: 8];
          end
        end
      end
      // status is read only, writes fall through
    end
  end

endmodule

// File: hw/dram_arbiter.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module dram_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    override_en,
  input  sniffer_pkg::port_id_e   override_sel,
  input  sniffer_pkg::mem_req_t   app_req,
  output logic                    app_rdy,
  output sniffer_pkg::mem_rsp_t   app_rsp,
  input  sniffer_pkg::mem_req_t   sniff_req,
  output logic                    sniff_rdy,
  output sniffer_pkg::mem_rsp_t   sniff_rsp,
  output sniffer_pkg::mem_req_t   ddr_req,
  input  logic                    ddr_rdy,
  input  sniffer_pkg::mem_rsp_t   ddr_rsp,
  output sniffer_pkg::arb_state_e arb_state,
  output logic                    conflict,
  input  logic                    conflict_clr
);

  localparam int PTR_W = $clog2(`SNIFF_RD_DEPTH);

  sniffer_pkg::port_id_e rd_owner [`SNIFF_RD_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        rd_count;
  logic                  rd_full;
  logic                  rd_push;
  sniffer_pkg::port_id_e head;
  sniffer_pkg::port_id_e last_q;
  logic                  out_valid;
  sniffer_pkg::mem_req_t out_q;
  logic                  advance;
  logic                  app_want;
  logic                  sniff_want;
  logic                  app_sel;
  logic                  sniff_sel;
  logic                  gnt_app;
  logic                  gnt_sniff;
  logic                  blocked_req;

  assign arb_state = override_en ? sniffer_pkg::ARB_OVERRIDE : sniffer_pkg::ARB_ROUND;

  // output register moves when empty or drained
  assign advance = !out_valid || ddr_rdy;
  assign rd_full = (rd_count == `SNIFF_RD_DEPTH);

  // a read waits while the tracking fifo is full
  assign app_want   = app_req.valid && !(app_req.cmd == sniffer_pkg::CMD_READ && rd_full);
  assign sniff_want = sniff_req.valid && !(sniff_req.cmd == sniffer_pkg::CMD_READ && rd_full);

  always_comb begin
    if (arb_state == sniffer_pkg::ARB_OVERRIDE) begin
      app_sel   = (override_sel == sniffer_pkg::PORT_APP);
      sniff_sel = (override_sel == sniffer_pkg::PORT_SNIFF);
    end else begin
      // alternate on contention
      app_sel   = !sniff_want || (last_q == sniffer_pkg::PORT_SNIFF);
      sniff_sel = !app_want || (last_q == sniffer_pkg::PORT_APP);
    end
  end

  assign gnt_app   = advance && app_want && app_sel;
  assign gnt_sniff = advance && sniff_want && sniff_sel;
  assign app_rdy   = gnt_app;
  assign sniff_rdy = gnt_sniff;

  assign rd_push = (gnt_app && app_req.cmd == sniffer_pkg::CMD_READ) ||
                   (gnt_sniff && sniff_req.cmd == sniffer_pkg::CMD_READ);

  // locked out port still asking
  assign blocked_req = (override_sel == sniffer_pkg::PORT_SNIFF) ? app_req.valid
                                                                 : sniff_req.valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      last_q    <= sniffer_pkg::PORT_SNIFF;
      conflict  <= 1'b0;
    end else begin
      if (advance) begin
        out_valid <= gnt_app || gnt_sniff;
      end
      if (gnt_app) begin
        last_q <= sniffer_pkg::PORT_APP;
      end else if (gnt_sniff) begin
        last_q <= sniffer_pkg::PORT_SNIFF;
      end
      // clear wins for one cycle, a pending request sets it again
      if (conflict_clr) begin
        conflict <= 1'b0;
      end else if (arb_state == sniffer_pkg::ARB_OVERRIDE && blocked_req) begin
        conflict <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_app) begin
      out_q <= app_req;
    end else if (gnt_sniff) begin
      out_q <= sniff_req;
    end
  end

  always_comb begin
    ddr_req       = out_q;
    ddr_req.valid = out_valid;
  end

  // owner of each issued read, oldest at rd_ptr
  always_ff @(posedge clk) begin
    if (rd_push) begin
      rd_owner[wr_ptr] <= gnt_app ? sniffer_pkg::PORT_APP : sniffer_pkg::PORT_SNIFF;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rd_count <= '0;
    end else begin
      if (rd_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (ddr_rsp.valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({rd_push, ddr_rsp.valid})
        2'b10: rd_count <= rd_count + 1'b1;
        2'b01: rd_count <= rd_count - 1'b1;
        default: rd_count <= rd_count;
      endcase
    end
  end

  assign head = rd_owner[rd_ptr];

  always_comb begin
    app_rsp.rdata   = ddr_rsp.rdata;
    app_rsp.valid   = ddr_rsp.valid && (head == sniffer_pkg::PORT_APP);
    sniff_rsp.rdata = ddr_rsp.rdata;
    sniff_rsp.valid = ddr_rsp.valid && (head == sniffer_pkg::PORT_SNIFF);
  end

endmodule

// File: hw/dram_sniffer_top.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module dram_sniffer_top (
  input  logic                  clk,
  input  logic                  rst,
  input  sniffer_pkg::apb_req_t ctrl_apb_in,
  output sniffer_pkg::apb_rsp_t ctrl_apb_out,
  input  sniffer_pkg::apb_req_t mem_apb_in,
  output sniffer_pkg::apb_rsp_t mem_apb_out,
  input  logic                  phy_ready,
  input  sniffer_pkg::mem_req_t app_req,
  output logic                  app_rdy,
  output sniffer_pkg::mem_rsp_t app_rsp,
  output sniffer_pkg::mem_req_t ddr_req,
  input  logic                  ddr_rdy,
  input  sniffer_pkg::mem_rsp_t ddr_rsp
);

  logic [`SNIFF_BASE_W-1:0] window_base;
  logic                     override_en;
  sniffer_pkg::port_id_e    override_sel;
  sniffer_pkg::arb_state_e  arb_state;
  logic                     conflict;
  logic                     conflict_clr;
  sniffer_pkg::win_state_e  win_state;

  // window side of the arbiter
  sniffer_pkg::mem_req_t    sniff_req;
  logic                     sniff_rdy;
  sniffer_pkg::mem_rsp_t    sniff_rsp;

  ctrl_regs u_ctrl_regs (
    .clk          (clk),
    .rst          (rst),
    .apb_in       (ctrl_apb_in),
    .apb_out      (ctrl_apb_out),
    .window_base  (window_base),
    .override_en  (override_en),
    .override_sel (override_sel),
    .arb_state    (arb_state),
    .conflict     (conflict),
    .conflict_clr (conflict_clr),
    .win_state    (win_state),
    .phy_ready    (phy_ready)
  );

  mem_window u_mem_window (
    .clk         (clk),
    .rst         (rst),
    .apb_in      (mem_apb_in),
    .apb_out     (mem_apb_out),
    .window_base (window_base),
    .mem_req     (sniff_req),
    .mem_rdy     (sniff_rdy),
    .mem_rsp     (sniff_rsp),
    .win_state   (win_state)
  );

  dram_arbiter u_dram_arbiter (
    .clk          (clk),
    .rst          (rst),
    .override_en  (override_en),
    .override_sel (override_sel),
    .app_req      (app_req),
    .app_rdy      (app_rdy),
    .app_rsp      (app_rsp),
    .sniff_req    (sniff_req),
    .sniff_rdy    (sniff_rdy),
    .sniff_rsp    (sniff_rsp),
    .ddr_req      (ddr_req),
    .ddr_rdy      (ddr_rdy),
    .ddr_rsp      (ddr_rsp),
    .arb_state    (arb_state),
    .conflict     (conflict),
    .conflict_clr (conflict_clr)
  );

endmodule

// File: hw/mem_window.sv
`timescale 1ns/1ps
`include "sniffer_settings.svh"

module mem_window (
  input  logic                     clk,
  input  logic                     rst,
  input  sniffer_pkg::apb_req_t    apb_in,
  output sniffer_pkg::apb_rsp_t    apb_out,
  input  logic [`SNIFF_BASE_W-1:0] window_base,
  output sniffer_pkg::mem_req_t    mem_req,
  input  logic                     mem_rdy,
  input  sniffer_pkg::mem_rsp_t    mem_rsp,
  output sniffer_pkg::win_state_e  win_state
);

  // zero pad above base and the nine paddr beat bits
  localparam int PAD_W  = `SNIFF_ADDR_W - `SNIFF_BASE_W - 9;
  localparam int LANE_W = `SNIFF_DATA_W / 2;
  localparam int LANE_M = `SNIFF_MASK_W / 2;

  sniffer_pkg::win_state_e  state_q;
  logic                     setup;
  logic                     start;
  logic                     pready_q;
  logic [LANE_W-1:0]        prdata_q;
  sniffer_pkg::mem_cmd_e    cmd_q;
  logic [`SNIFF_ADDR_W-1:0] addr_q;
  logic [`SNIFF_DATA_W-1:0] wdata_q;
  logic [`SNIFF_MASK_W-1:0] mask_q;
  logic                     lane_q;
  logic [`SNIFF_MASK_W-1:0] wr_mask;

  // only the setup phase starts an access, so the completing
  // access phase cannot retrigger
  assign setup = apb_in.psel && !apb_in.penable;
  assign start = (state_q == sniffer_pkg::WIN_IDLE) && setup;

  // unused lane fully masked, strobes inverted into the active lane
  always_comb begin
    if (apb_in.paddr[2]) begin
      wr_mask = {~apb_in.pstrb, {LANE_M{1'b1}}};
    end else begin
      wr_mask = {{LANE_M{1'b1}}, ~apb_in.pstrb};
    end
  end

  // command payload captured at setup
  always_ff @(posedge clk) begin
    if (start) begin
      cmd_q   <= apb_in.pwrite ? sniffer_pkg::CMD_WRITE : sniffer_pkg::CMD_READ;
      addr_q  <= {{PAD_W{1'b0}}, window_base, apb_in.paddr[11:3]};
      wdata_q <= {2{apb_in.pwdata}};
      mask_q  <= apb_in.pwrite ? wr_mask : {`SNIFF_MASK_W{1'b1}};
      lane_q  <= apb_in.paddr[2];
    end
    if (state_q == sniffer_pkg::WIN_WAIT_RD && mem_rsp.valid) begin
      if (lane_q) begin
        prdata_q <= mem_rsp.rdata[LANE_W +: LANE_W];
      end else begin
        prdata_q <= mem_rsp.rdata[LANE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= sniffer_pkg::WIN_IDLE;
      pready_q <= 1'b0;
    end else begin
      pready_q <= 1'b0;
      case (state_q)
        sniffer_pkg::WIN_IDLE: begin
          if (setup) begin
            state_q <= sniffer_pkg::WIN_CMD;
          end
        end
        sniffer_pkg::WIN_CMD: begin
          if (mem_rdy) begin
            // writes finish on acceptance, reads wait for data
            if (cmd_q == sniffer_pkg::CMD_WRITE) begin
              state_q  <= sniffer_pkg::WIN_IDLE;
              pready_q <= 1'b1;
            end else begin
              state_q <= sniffer_pkg::WIN_WAIT_RD;
            end
          end
        end
        sniffer_pkg::WIN_WAIT_RD: begin
          if (mem_rsp.valid) begin
            state_q  <= sniffer_pkg::WIN_IDLE;
            pready_q <= 1'b1;
          end
        end
        default: begin
          state_q <= sniffer_pkg::WIN_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    mem_req.valid = (state_q == sniffer_pkg::WIN_CMD);
    mem_req.cmd   = cmd_q;
    mem_req.addr  = addr_q;
    mem_req.wdata = wdata_q;
    mem_req.mask  = mask_q;
  end

  assign apb_out.pready  = pready_q;
  assign apb_out.pslverr = 1'b0;
  assign apb_out.prdata  = prdata_q;
  assign win_state       = state_q;

endmodule

// File: hw/sniffer_pkg.sv
`include "sniffer_settings.svh"

package sniffer_pkg;

  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } mem_cmd_e;

  typedef enum logic {
    ARB_ROUND    = 1'b0,
    ARB_OVERRIDE = 1'b1
  } arb_state_e;

  typedef enum logic [1:0] {
    WIN_IDLE    = 2'd0,
    WIN_CMD     = 2'd1,
    WIN_WAIT_RD = 2'd2
  } win_state_e;

  typedef enum logic {
    PORT_APP   = 1'b0,
    PORT_SNIFF = 1'b1
  } port_id_e;

  // mask bit high means the byte is left alone
  typedef struct packed {
    logic                     valid;
    mem_cmd_e                 cmd;
    logic [`SNIFF_ADDR_W-1:0] addr;
    logic [`SNIFF_DATA_W-1:0] wdata;
    logic [`SNIFF_MASK_W-1:0] mask;
  } mem_req_t;

  typedef struct packed {
    logic                     valid;
    logic [`SNIFF_DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

// File: hw/sniffer_settings.svh
`ifndef SNIFFER_SETTINGS_SVH
`define SNIFFER_SETTINGS_SVH

// dram beat geometry
`define SNIFF_ADDR_W 32
`define SNIFF_DATA_W 64
`define SNIFF_MASK_W 8

// upper beat-address bits set by software
`define SNIFF_BASE_W 16

// reads in flight through the arbiter
`define SNIFF_RD_DEPTH 4

// control slave register offsets
`define SNIFF_REG_CTRL   12'h000
`define SNIFF_REG_BASE   12'h004
`define SNIFF_REG_STATUS 12'h008

`endif
